//--- Makefile
TOP = alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- include/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// sizing of the arithmetic unit

// width of one processor bus word
`define ALU_WIDTH 8

// bits handled by one 74LS283-style slice
`define ALU_SLICE 4

// number of chained slices
`define ALU_SLICES (`ALU_WIDTH / `ALU_SLICE)

// carry chain is one bit longer than the slice count
`define ALU_CARRIES (`ALU_SLICES + 1)

`endif

//--- logic/alu_pkg.sv
`include "alu_params.svh"

package alu_pkg;

  // full bus word as seen on the processor bus
  typedef logic [`ALU_WIDTH-1:0] word_t;

  // one slice operand or slice sum
  typedef logic [`ALU_SLICE-1:0] nibble_t;

  // flag register layout
  localparam int FLAG_CARRY = 0;  // carry out of the top slice
  localparam int FLAG_ZERO  = 1;  // result all zeros

  // width of the flag register
  localparam int FLAG_BITS = 2;

  // flag vector type
  typedef logic [FLAG_BITS-1:0] flags_t;

endpackage

//--- logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_params.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,     // sync, active low
  input  word_t      bus_in,    // processor bus in
  input  logic       a_load,    // load A from bus
  input  logic       b_load,    // load B from bus
  input  logic       subtract,  // 1 = A minus B
  input  logic       alu_out,   // put result on bus
  input  logic       flag_fi,   // capture carry and zero
  input  logic       flag_clr,  // zero the flags
  output word_t      bus_out,   // result or zero
  output logic [1:0] flag_out   // {zero, carry}
);

  nibble_t [`ALU_SLICES-1:0]  a_nib;    // A per slice
  nibble_t [`ALU_SLICES-1:0]  b_nib;    // B or ~B per slice
  nibble_t [`ALU_SLICES-1:0]  sum_nib;  // slice sums
  logic    [`ALU_CARRIES-1:0] carry;    // carry chain, [0] is subtract

  // operand registers and B inversion
  operand_stage u_operands (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_in   (bus_in),
    .a_load   (a_load),
    .b_load   (b_load),
    .subtract (subtract),
    .a_nib    (a_nib),
    .b_nib    (b_nib),
    .cin      (carry[0])  // two's complement +1
  );

  // chained lookahead slices, ripple only between slices
  genvar i;
  generate
    for (i = 0; i < `ALU_SLICES; i++) begin : g_slice
      quad_adder u_adder (
        .a    (a_nib[i]),
        .b    (b_nib[i]),
        .cin  (carry[i]),    // from previous slice
        .sum  (sum_nib[i]),
        .cout (carry[i+1])   // to next slice
      );
    end
  endgenerate

  // flags and bus gating
  flag_stage u_flags (
    .clk      (clk),
    .rst_n    (rst_n),
    .sum_nib  (sum_nib),
    .cout     (carry[`ALU_SLICES]),  // carry out of the top slice
    .alu_out  (alu_out),
    .flag_fi  (flag_fi),
    .flag_clr (flag_clr),
    .bus_out  (bus_out),
    .flag_out (flag_out)
  );

endmodule

`default_nettype wire

//--- logic/flag_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_params.svh"

module flag_stage
  import alu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,     // sync, active low
  input  nibble_t [`ALU_SLICES-1:0]  sum_nib,   // slice sums, low slice first
  input  logic                       cout,      // carry out of top slice
  input  logic                       alu_out,   // drive result onto bus
  input  logic                       flag_fi,   // capture flags
  input  logic                       flag_clr,  // clear flags, beats flag_fi
  output word_t                      bus_out,   // zero when not driving
  output logic [1:0]                 flag_out   // {zero, carry}
);

  word_t  result;     // joined slice sums
  logic   zero;       // result all zeros
  flags_t flag_d;     // next flag word
  flags_t flag_reg;   // flag register

  // reassemble the word from the slices
  genvar i;
  generate
    for (i = 0; i < `ALU_SLICES; i++) begin : g_join
      assign result[i*`ALU_SLICE +: `ALU_SLICE] = sum_nib[i];
    end
  endgenerate

  // nor of all result bits
  assign zero = ~|result;

  // flag word in register layout
  always_comb begin
    flag_d             = '0;
    flag_d[FLAG_CARRY] = cout;  // top carry, also the no-borrow bit
    flag_d[FLAG_ZERO]  = zero;
  end

  // flag register, clear wins, otherwise hold unless strobed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flag_reg <= '0;
    end else if (flag_clr) begin
      flag_reg <= '0;  // clear overrides capture
    end else if (flag_fi) begin
      flag_reg <= flag_d;  // capture current result
    end
  end

  assign flag_out = flag_reg;

  // no tri-state here, undriven bus reads as zero
  assign bus_out = alu_out ? result : '0;

  // a clear always leaves both flags low
  flag_clr_zeros: assert property (
    @(posedge clk) disable iff (!rst_n)
    flag_clr |=> (flag_out == '0)
  ) else $error("flags not cleared");

  // flags only move on a strobe
  flag_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!flag_fi && !flag_clr) |=> $stable(flag_out)
  ) else $error("flags changed without a strobe");

endmodule

`default_nettype wire

//--- logic/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_params.svh"

module operand_stage
  import alu_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,     // sync, active low
  input  word_t                      bus_in,    // processor bus
  input  logic                       a_load,    // latch bus into A
  input  logic                       b_load,    // latch bus into B
  input  logic                       subtract,  // level, 1 = A minus B
  output nibble_t [`ALU_SLICES-1:0]  a_nib,     // A split per slice
  output nibble_t [`ALU_SLICES-1:0]  b_nib,     // B or ~B split per slice
  output logic                       cin        // carry into slice 0
);

  word_t a_reg;  // A operand register
  word_t b_reg;  // B operand register
  word_t b_eff;  // B after conditional inversion

  // A register, 74LS173-like load enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_reg <= '0;  // cleared with the rest of the unit
    end else if (a_load) begin
      a_reg <= bus_in;  // grab bus word
    end
  end

  // B register, independent strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_reg <= '0;
    end else if (b_load) begin
      b_reg <= bus_in;  // may load together with A
    end
  end

  // xor-style inverter row on B for two's complement
  assign b_eff = subtract ? ~b_reg : b_reg;

  // the +1 of two's complement enters as slice-0 carry
  assign cin = subtract;

  // split both operands into slice nibbles
  genvar i;
  generate
    for (i = 0; i < `ALU_SLICES; i++) begin : g_split
      assign a_nib[i] = a_reg[i*`ALU_SLICE +: `ALU_SLICE];  // low slice first
      assign b_nib[i] = b_eff[i*`ALU_SLICE +: `ALU_SLICE];
    end
  endgenerate

  // a load strobe must land the sampled bus word in the register
  a_load_lands: assert property (
    @(posedge clk) disable iff (!rst_n)
    a_load |=> (a_reg == $past(bus_in))
  ) else $error("A register missed a load");

  b_load_lands: assert property (
    @(posedge clk) disable iff (!rst_n)
    b_load |=> (b_reg == $past(bus_in))
  ) else $error("B register missed a load");

endmodule

`default_nettype wire

//--- logic/quad_adder.sv
`timescale 1ns/1ps
`default_nettype none
`include "alu_params.svh"

module quad_adder
  import alu_pkg::*;
(
  input  nibble_t a,     // operand a nibble
  input  nibble_t b,     // operand b nibble, already inverted for subtract
  input  logic    cin,   // carry into bit 0
  output nibble_t sum,   // nibble sum
  output logic    cout   // carry out of bit 3
);

  nibble_t g;  // per-bit generate
  nibble_t p;  // per-bit propagate
  nibble_t c;  // carry into each bit

  // generate and propagate terms, one gate level
  assign g = a & b;  // both ones always carry
  assign p = a ^ b;  // exactly one one passes the carry

  // bit 0 carry comes straight from the slice input
  assign c[0] = cin;

  // lookahead carries, each a flat sum of products
  assign c[1] = g[0]
              | (p[0] & cin);  // two terms

  assign c[2] = g[1]
              | (p[1] & g[0])
              | (p[1] & p[0] & cin);  // three terms

  assign c[3] = g[2]
              | (p[2] & g[1])
              | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);  // four terms

  // slice carry out, same lookahead form as the '283
  assign cout = g[3]
              | (p[3] & g[2])
              | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0])
              | (p[3] & p[2] & p[1] & p[0] & cin);  // five terms

  // sum bits, propagate xor incoming carry
  assign sum = p ^ c;

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/alu_pkg.sv
logic/quad_adder.sv
logic/operand_stage.sv
logic/flag_stage.sv
logic/alu_top.sv
test/alu_tb.sv

//--- test/alu_tb.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int RESET_CYCLES = 16;            // rst_n low this long
  localparam int ROWS         = 16;            // directed table size
  localparam int RANDOM_COUNT = 200;           // random operand pairs
  localparam int STEPS        = 4;             // falling edges per operation
  localparam int MARGIN       = 1120;          // directed checks plus slack
  localparam int CYCLE_LIMIT  = RESET_CYCLES + (ROWS + RANDOM_COUNT) * STEPS + MARGIN;
  localparam logic [31:0] SEED = 32'hcfc2_7a02;

  // columns: a, b, subtract, result, carry, zero
  localparam logic [26:0] OP_TABLE [ROWS] = '{
    {8'd0,   8'd0,   1'b0, 8'd0,   1'b0, 1'b1},  // 0+0
    {8'd255, 8'd1,   1'b0, 8'd0,   1'b1, 1'b1},  // wraps to zero
    {8'd200, 8'd100, 1'b0, 8'd44,  1'b1, 1'b0},  // 300 mod 256
    {8'd5,   8'd5,   1'b1, 8'd0,   1'b1, 1'b1},  // equal operands
    {8'd3,   8'd7,   1'b1, 8'd252, 1'b0, 1'b0},  // borrow
    {8'd128, 8'd1,   1'b1, 8'd127, 1'b1, 1'b0},  // sign boundary
    {8'd0,   8'd0,   1'b1, 8'd0,   1'b1, 1'b1},  // 0-0 still carries
    {8'd255, 8'd255, 1'b1, 8'd0,   1'b1, 1'b1},
    {8'd1,   8'd1,   1'b0, 8'd2,   1'b0, 1'b0},
    {8'd127, 8'd1,   1'b0, 8'd128, 1'b0, 1'b0},
    {8'd255, 8'd255, 1'b0, 8'd254, 1'b1, 1'b0},  // largest sum
    {8'd0,   8'd1,   1'b1, 8'd255, 1'b0, 1'b0},  // borrow from zero
    {8'd100, 8'd200, 1'b1, 8'd156, 1'b0, 1'b0},
    {8'd15,  8'd1,   1'b0, 8'd16,  1'b0, 1'b0},  // carry between slices
    {8'd16,  8'd1,   1'b1, 8'd15,  1'b1, 1'b0},  // borrow between slices
    {8'd240, 8'd16,  1'b0, 8'd0,   1'b1, 1'b1}   // top slice carry only
  };

  logic       clk;
  logic       rst_n;
  word_t      bus_in;
  logic       a_load;
  logic       b_load;
  logic       subtract;
  logic       alu_out;
  logic       flag_fi;
  logic       flag_clr;
  word_t      bus_out;
  logic [1:0] flag_out;
  logic [1:0] flags_model;                     // flags the unit should hold
  int         cycles = 0;                      // timeout counter

  alu_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_in   (bus_in),
    .a_load   (a_load),
    .b_load   (b_load),
    .subtract (subtract),
    .alu_out  (alu_out),
    .flag_fi  (flag_fi),
    .flag_clr (flag_clr),
    .bus_out  (bus_out),
    .flag_out (flag_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                     // 10 ns period
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected {result, zero, carry} from the arithmetic rules
  function automatic logic [9:0] model_op(input word_t a, input word_t b, input logic sub);
    logic [8:0] wide;
    word_t      res;
    logic       carry;
    if (sub) begin
      res   = a - b;                           // mod 256
      carry = (a >= b);                        // no borrow
    end else begin
      wide  = {1'b0, a} + {1'b0, b};
      res   = wide[7:0];
      carry = wide[8];                         // bit 8 of the sum
    end
    return {res, (res == 8'd0), carry};
  endfunction

  task automatic report_failure();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("[FAIL] %0t ns: %s expected 8'h%02h, got 8'h%02h",
               $time, name, expected, actual);
      report_failure();
    end
  endtask

  // load A, load B, set mode and strobes, then check
  task automatic run_op(input word_t a, input word_t b, input logic sub, input logic capture,
                        input word_t exp_res, input logic exp_carry, input logic exp_zero);
    logic [1:0] exp_flags;
    exp_flags = flags_model;                   // hold unless captured
    if (capture) begin
      exp_flags[FLAG_CARRY] = exp_carry;
      exp_flags[FLAG_ZERO]  = exp_zero;
    end
    @(negedge clk);
    bus_in = a;
    a_load = 1'b1;
    @(negedge clk);
    a_load = 1'b0;
    bus_in = b;
    b_load = 1'b1;
    @(negedge clk);
    b_load   = 1'b0;
    bus_in   = '0;
    subtract = sub;
    alu_out  = 1'b1;
    flag_fi  = capture;
    @(negedge clk);
    check_value("bus_out", exp_res, bus_out);  // combinational result
    check_value("flag_out", {6'b0, exp_flags}, {6'b0, flag_out});
    flag_fi     = 1'b0;
    flags_model = exp_flags;
  endtask

  // clear and capture in the same cycle, clear must win
  task automatic run_clear();
    assert (flag_out != 2'b00) else begin
      $display("Flags were already zero before the clear test, so it proves nothing");
      report_failure();
    end
    @(negedge clk);
    flag_clr = 1'b1;
    flag_fi  = 1'b1;
    @(negedge clk);
    check_value("flag_out", 8'h00, {6'b0, flag_out});
    flag_clr    = 1'b0;
    flag_fi     = 1'b0;
    flags_model = 2'b00;
  endtask

  // operands change while the unit is off the bus
  task automatic run_gated(input word_t a, input word_t b, input logic sub, input word_t exp_res);
    @(negedge clk);
    alu_out  = 1'b0;
    subtract = sub;
    bus_in   = a;
    a_load   = 1'b1;
    @(negedge clk);
    check_value("bus_out", 8'h00, bus_out);
    a_load = 1'b0;
    bus_in = b;
    b_load = 1'b1;
    @(negedge clk);
    check_value("bus_out", 8'h00, bus_out);
    b_load = 1'b0;
    @(negedge clk);
    check_value("bus_out", 8'h00, bus_out);    // new operands, still quiet
    alu_out = 1'b1;
    @(negedge clk);
    check_value("bus_out", exp_res, bus_out);  // result appears once enabled
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      report_failure();
    end
  end

  initial begin
    int          i;
    logic [26:0] row;
    logic [31:0] rnd;
    logic [9:0]  model_out;
    word_t       op_a;
    word_t       op_b;
    logic        op_sub;

    rst_n       = 1'b0;
    bus_in      = '0;
    a_load      = 1'b0;
    b_load      = 1'b0;
    subtract    = 1'b0;
    alu_out     = 1'b0;
    flag_fi     = 1'b0;
    flag_clr    = 1'b0;
    flags_model = 2'b00;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n   = 1'b1;
    alu_out = 1'b1;                            // drive bus, no loads
    @(negedge clk);
    check_value("bus_out", 8'h00, bus_out);    // cleared registers
    check_value("flag_out", 8'h00, {6'b0, flag_out});

    for (i = 0; i < ROWS; i++) begin
      row = OP_TABLE[i];
      run_op(row[26:19], row[18:11], row[10], 1'b1, row[9:2], row[1], row[0]);
    end

    // flags stay 2'b11 from the last row, capture would give 2'b01
    run_op(8'd255, 8'd255, 1'b0, 1'b0, 8'd254, 1'b1, 1'b0);
    run_clear();
    run_gated(8'haa, 8'h55, 1'b0, 8'hff);
    run_gated(8'h10, 8'h30, 1'b1, 8'he0);

    rnd = SEED;
    for (i = 0; i < RANDOM_COUNT; i++) begin
      rnd       = xorshift32(rnd);
      op_a      = rnd[7:0];
      op_b      = rnd[15:8];
      op_sub    = rnd[16];
      model_out = model_op(op_a, op_b, op_sub);
      run_op(op_a, op_b, op_sub, 1'b1, model_out[9:2], model_out[0], model_out[1]);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
